/* tb.f */
gesture_pkg.sv
frame_stats_if.sv
centroid_if.sv
led_pixel_accumulator.sv
serial_divider.sv
frame_centroid_buffer.sv
motion_gesture_tracker.sv
led_gesture_top.sv
tb_led_gesture.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_led_gesture
FLIST     ?= tb.f
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

.PHONY: all build run clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "Simulation finished: PASS" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_led_gesture.sv */
`timescale 1ns/1ps

module tb_led_gesture import gesture_pkg::*; ();

    typedef struct packed {
        logic [1:0] owner;
        rgb444_t    rgb;
        coord_x_t   x;
        coord_y_t   y;
    } pixel_t;

    logic     clk_65mhz = 1'b0;
    logic     reset_8frame_delta_values;
    logic     pixel_valid;
    rgb444_t  pixel_rgb;
    coord_x_t pixel_x;
    coord_y_t pixel_y;
    logic     frame_done;
    logic     actions_valid;
    logic     p1_punch, p1_kick, p1_move_forwards, p1_move_backwards;
    logic     p2_punch, p2_kick, p2_move_forwards, p2_move_backwards;

    integer seed;
    int     errors;
    int     checks;
    int     valid_count;
    int     windows_done;
    // model centroids with player 1 at index 0
    int     cur_x[2], cur_y[2], cur_s[2];
    int     win_x[2], win_y[2], win_s[2];

    led_gesture_top led_gesture_top_i (.*);

    always #4 clk_65mhz = ~clk_65mhz;

    always @(negedge clk_65mhz) begin
        if (actions_valid === 1'b1) begin
            valid_count++;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checking and the reference model
    //////////////////////////////////////////////////////////////////////

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error at %0t ns: %s, got %0d, expected %0d",
                     $time, msg, actual, expected);
        end
    endtask

    // {punch, kick, fwd, back} from the net 8-frame change
    function automatic logic [3:0] expected_actions(input int dx, input int dy, input int ds);
        int ax;
        int ay;
        int as_mag;
        ax     = dx < 0 ? -dx : dx;
        ay     = dy < 0 ? -dy : dy;
        as_mag = ds < 0 ? -ds : ds;
        if (as_mag > int'(MOVE_SIZE_MIN)) begin
            return {2'b00, ds < 0, ds > 0};
        end
        return {ax > int'(PUNCH_DX_MIN) && ay < int'(PUNCH_DY_MAX),
                ay > int'(KICK_DY_MIN) && ax < int'(KICK_DX_MAX), 2'b00};
    endfunction

    task automatic drive_cycle(input logic valid, input rgb444_t rgb, input coord_x_t x,
                               input coord_y_t y, input logic fd);
        @(posedge clk_65mhz);
        #1;
        pixel_valid = valid;
        pixel_rgb   = rgb;
        pixel_x     = x;
        pixel_y     = y;
        frame_done  = fd;
    endtask

    // one frame of pixels followed by frame_done high and its falling edge
    task automatic send_frame(input int p1x, input int p1y, input int p1n, input int p2x,
                              input int p2y, input int p2n, input bit mixed);
        pixel_t q[$];
        int     cnt[2] = '{0, 0};
        int     sx[2] = '{0, 0};
        int     sy[2] = '{0, 0};
        int     r;
        int     p;
        for (int i = 0; i < p1n; i++) begin
            q.push_back({2'd1, (mixed && i % 2 == 1) ? 12'hC11 : 12'hF00,
                         coord_x_t'(p1x + i % 2), coord_y_t'(p1y + (i / 2) % 2)});
        end
        for (int i = 0; i < p2n; i++) begin
            q.push_back({2'd2, (mixed && i % 2 == 1) ? 12'hEEE : 12'hFFF,
                         coord_x_t'(p2x + i % 2), coord_y_t'(p2y + (i / 2) % 2)});
        end
        // colours just outside each rule sit far from the blobs
        if (mixed) begin
            for (int i = 0; i < 12; i++) begin
                q.push_back({2'd0, 12'hB11, coord_x_t'(511), coord_y_t'(p1y)});
                q.push_back({2'd0, 12'hDEE, coord_x_t'(0), coord_y_t'(p2y)});
            end
        end
        // jittered noise with red never above 11
        for (int i = 0; i < 4; i++) begin
            r = $random(seed);
            q.push_back({2'd0, 4'($unsigned(r) % 12), r[11:4],
                         coord_x_t'(r >> 12), coord_y_t'(r >> 21)});
        end
        foreach (q[i]) begin
            drive_cycle(1'b1, q[i].rgb, q[i].x, q[i].y, 1'b0);
            if (q[i].owner != 2'd0) begin
                p = int'(q[i].owner) - 1;
                cnt[p]++;
                sx[p] += int'(q[i].x);
                sy[p] += int'(q[i].y);
            end
        end
        repeat (40) drive_cycle(1'b0, '0, '0, '0, 1'b1);
        drive_cycle(1'b0, '0, '0, '0, 1'b0);
        for (int i = 0; i < 2; i++) begin
            cur_s[i] = cnt[i];
            // empty frame holds the old position
            if (cnt[i] != 0) begin
                cur_x[i] = sx[i] / cnt[i];
                cur_y[i] = sy[i] / cnt[i];
            end
        end
    endtask

    task automatic wait_actions();
        int cycles;
        cycles = 0;
        while (actions_valid !== 1'b1 && cycles < 2000) begin
            @(negedge clk_65mhz);
            cycles++;
        end
        if (actions_valid !== 1'b1) begin
            $display("Timeout: actions_valid did not pulse within 2000 cycles");
            $display("checks %0d, errors %0d, timeouts 1", checks, errors);
            $display("Simulation finished: FAIL");
            $finish;
        end
    endtask

    task automatic check_window();
        logic [3:0] exp_p[2];
        @(posedge clk_65mhz);
        #1;
        for (int i = 0; i < 2; i++) begin
            exp_p[i] = expected_actions(cur_x[i] - win_x[i], cur_y[i] - win_y[i],
                                        cur_s[i] - win_s[i]);
            win_x[i] = cur_x[i];
            win_y[i] = cur_y[i];
            win_s[i] = cur_s[i];
        end
        windows_done++;
        check(32'({p1_punch, p1_kick, p1_move_forwards, p1_move_backwards}),
              32'(exp_p[0]), "player 1 {punch, kick, fwd, back}");
        check(32'({p2_punch, p2_kick, p2_move_forwards, p2_move_backwards}),
              32'(exp_p[1]), "player 2 {punch, kick, fwd, back}");
        check(32'(valid_count), 32'(windows_done), "actions_valid pulse count");
    endtask

    // frame k places each blob at start + step * k
    task automatic run_window(input int p1x, input int p1y, input int p1n, input int p1_dx,
                              input int p1_dn, input int p2x, input int p2y, input int p2n,
                              input int p2_dx, input int p2_dy, input int p2_frames,
                              input bit mixed);
        for (int k = 1; k <= FRAMES_PER_MOTION; k++) begin
            send_frame(p1x + p1_dx * k, p1y, p1n + p1_dn * k, p2x + p2_dx * k,
                       p2y + p2_dy * k, (k <= p2_frames) ? p2n : 0, mixed);
            check(32'(valid_count), 32'(windows_done), "actions_valid inside a window");
            if (windows_done == 0) begin
                check(32'({p1_punch, p1_kick, p1_move_forwards, p1_move_backwards,
                           p2_punch, p2_kick, p2_move_forwards, p2_move_backwards}),
                      32'd0, "actions before the first window");
            end
        end
        wait_actions();
        check_window();
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic idle_after_reset();
        run_window(100, 60, 40, 0, 0, 300, 150, 30, 0, 0, 8, 1'b0);
    endtask

    task automatic steady_blob();
        run_window(100, 60, 40, 0, 0, 300, 150, 30, 0, 0, 8, 1'b0);
        check(32'({p1_punch, p1_kick, p1_move_forwards, p1_move_backwards}), 32'd0,
              "steady player 1 actions");
    endtask

    task automatic punch_window();
        run_window(100, 60, 40, 12, 0, 300, 150, 30, 0, 0, 8, 1'b0);
        check(32'(p1_punch), 32'd1, "p1_punch after x +96");
        check(32'({p2_punch, p2_kick, p2_move_forwards, p2_move_backwards}), 32'd0,
              "static player 2 actions");
    endtask

    task automatic kick_and_priority();
        run_window(196, 60, 40, 0, 0, 300, 150, 30, 0, 10, 8, 1'b1);
        check(32'(p2_kick), 32'd1, "p2_kick after y +80");
    endtask

    task automatic size_movement();
        // size ramps by exactly the move threshold up to 88
        run_window(196, 60, 40, 0, 6, 300, 230, 30, 0, 0, 8, 1'b0);
        run_window(196, 60, 88, 12, -8, 300, 230, 30, 0, 0, 8, 1'b0);
        check(32'({p1_move_forwards, p1_punch}), 32'b10, "p1 forwards without punch");
        run_window(292, 60, 24, 0, 8, 300, 230, 30, 0, 0, 8, 1'b0);
        check(32'(p1_move_backwards), 32'd1, "p1_move_backwards after size +64");
    endtask

    task automatic empty_p2_frames();
        run_window(292, 60, 88, 0, 0, 300, 230, 30, 24, 0, 3, 1'b0);
        check(32'(p2_punch), 32'd1, "p2_punch with held position");
    endtask

    initial begin
        seed                      = 32'hdbddc56c;
        reset_8frame_delta_values = 1'b1;
        pixel_valid               = 1'b0;
        pixel_rgb                 = '0;
        pixel_x                   = '0;
        pixel_y                   = '0;
        frame_done                = 1'b0;
        repeat (5) @(posedge clk_65mhz);
        #1;
        reset_8frame_delta_values = 1'b0;
        idle_after_reset();
        steady_blob();
        punch_window();
        kick_and_priority();
        size_movement();
        empty_p2_frames();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* led_gesture_top.sv */
`timescale 1ns/1ps

module led_gesture_top import gesture_pkg::*; (
    input  logic     clk_65mhz,
    input  logic     reset_8frame_delta_values,
    input  logic     pixel_valid,
    input  rgb444_t  pixel_rgb,
    input  coord_x_t pixel_x,
    input  coord_y_t pixel_y,
    input  logic     frame_done,
    output logic     actions_valid,
    output logic     p1_punch,
    output logic     p1_kick,
    output logic     p1_move_forwards,
    output logic     p1_move_backwards,
    output logic     p2_punch,
    output logic     p2_kick,
    output logic     p2_move_forwards,
    output logic     p2_move_backwards
);

    frame_stats_if stats_bus ();
    centroid_if    centroid_bus ();

    // coordinates arrive already mirrored
    led_pixel_accumulator led_pixel_accumulator_i (
        .clk_65mhz                 (clk_65mhz),
        .reset_8frame_delta_values (reset_8frame_delta_values),
        .pixel_valid               (pixel_valid),
        .pixel_rgb                 (pixel_rgb),
        .pixel_x                   (pixel_x),
        .pixel_y                   (pixel_y),
        .frame_done                (frame_done),
        .stats                     (stats_bus.source)
    );

    frame_centroid_buffer frame_centroid_buffer_i (
        .clk_65mhz                 (clk_65mhz),
        .reset_8frame_delta_values (reset_8frame_delta_values),
        .stats                     (stats_bus.sink),
        .centroid                  (centroid_bus.source)
    );

    motion_gesture_tracker motion_gesture_tracker_i (
        .clk_65mhz                 (clk_65mhz),
        .reset_8frame_delta_values (reset_8frame_delta_values),
        .centroid                  (centroid_bus.sink),
        .actions_valid             (actions_valid),
        .p1_punch                  (p1_punch),
        .p1_kick                   (p1_kick),
        .p1_move_forwards          (p1_move_forwards),
        .p1_move_backwards         (p1_move_backwards),
        .p2_punch                  (p2_punch),
        .p2_kick                   (p2_kick),
        .p2_move_forwards          (p2_move_forwards),
        .p2_move_backwards         (p2_move_backwards)
    );

endmodule

/* motion_gesture_tracker.sv */
`timescale 1ns/1ps

module motion_gesture_tracker import gesture_pkg::*; (
    input  logic     clk_65mhz,
    input  logic     reset_8frame_delta_values,
    centroid_if.sink centroid,
    output logic     actions_valid,
    output logic     p1_punch,
    output logic     p1_kick,
    output logic     p1_move_forwards,
    output logic     p1_move_backwards,
    output logic     p2_punch,
    output logic     p2_kick,
    output logic     p2_move_forwards,
    output logic     p2_move_backwards
);

    coord_x_t     [NUM_PLAYERS-1:0] prev_x;
    coord_y_t     [NUM_PLAYERS-1:0] prev_y;
    pixel_count_t [NUM_PLAYERS-1:0] prev_size;
    delta2_t      [NUM_PLAYERS-1:0] d2_x, d2_y, d2_s;
    logic         [NUM_PLAYERS-1:0] d2_x_neg, d2_y_neg, d2_s_neg;
    delta8_t      [NUM_PLAYERS-1:0] acc_x, acc_y, acc_s;
    logic         [NUM_PLAYERS-1:0] acc_x_neg, acc_y_neg, acc_s_neg;
    logic         [NUM_PLAYERS-1:0] punch, kick, fwd, back;
    logic [FRAME_CNT_W-1:0]         update_cnt;
    logic                           window_end;

    // sign is set when the value shrank
    function automatic logic [$bits(delta2_t):0] delta2(input pixel_count_t cur,
                                                         input pixel_count_t prev);
        logic         neg;
        pixel_count_t diff;
        neg  = prev > cur;
        diff = neg ? prev - cur : cur - prev;
        return {neg, delta2_t'(diff)};
    endfunction

    // sign-magnitude sum, the larger magnitude keeps its sign
    function automatic logic [$bits(delta8_t):0] accumulate(input logic acc_neg,
                                                             input delta8_t acc,
                                                             input logic d_neg,
                                                             input delta2_t d);
        delta8_t d_ext;
        d_ext = delta8_t'(d);
        if (acc_neg == d_neg) begin
            return {acc_neg, acc + d_ext};
        end else if (acc > d_ext) begin
            return {acc_neg, acc - d_ext};
        end
        return {d_neg, d_ext - acc};
    endfunction

    always_comb begin
        for (int p = 0; p < NUM_PLAYERS; p++) begin
            {d2_x_neg[p], d2_x[p]} = delta2(pixel_count_t'(centroid.x[p]),
                                            pixel_count_t'(prev_x[p]));
            {d2_y_neg[p], d2_y[p]} = delta2(pixel_count_t'(centroid.y[p]),
                                            pixel_count_t'(prev_y[p]));
            {d2_s_neg[p], d2_s[p]} = delta2(centroid.size[p], prev_size[p]);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // 8-frame window and action decision
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_65mhz) begin
        if (reset_8frame_delta_values) begin
            prev_x        <= '0;
            prev_y        <= '0;
            prev_size     <= '0;
            {acc_x, acc_y, acc_s}             <= '0;
            {acc_x_neg, acc_y_neg, acc_s_neg} <= '0;
            {punch, kick, fwd, back}          <= '0;
            update_cnt    <= '0;
            window_end    <= 1'b0;
            actions_valid <= 1'b0;
        end else begin
            window_end    <= 1'b0;
            actions_valid <= window_end;
            if (centroid.centroid_update) begin
                prev_x    <= centroid.x;
                prev_y    <= centroid.y;
                prev_size <= centroid.size;
                for (int p = 0; p < NUM_PLAYERS; p++) begin
                    {acc_x_neg[p], acc_x[p]} <= accumulate(acc_x_neg[p], acc_x[p],
                                                           d2_x_neg[p], d2_x[p]);
                    {acc_y_neg[p], acc_y[p]} <= accumulate(acc_y_neg[p], acc_y[p],
                                                           d2_y_neg[p], d2_y[p]);
                    {acc_s_neg[p], acc_s[p]} <= accumulate(acc_s_neg[p], acc_s[p],
                                                           d2_s_neg[p], d2_s[p]);
                end
                if (update_cnt == FRAME_CNT_W'(FRAMES_PER_MOTION - 1)) begin
                    update_cnt <= '0;
                    window_end <= 1'b1;
                end else begin
                    update_cnt <= update_cnt + 1'b1;
                end
            end
            if (window_end) begin
                for (int p = 0; p < NUM_PLAYERS; p++) begin
                    // a big size change means the player stepped
                    if (acc_s[p] > MOVE_SIZE_MIN) begin
                        fwd[p]   <= acc_s_neg[p];
                        back[p]  <= !acc_s_neg[p];
                        punch[p] <= 1'b0;
                        kick[p]  <= 1'b0;
                    end else begin
                        fwd[p]   <= 1'b0;
                        back[p]  <= 1'b0;
                        punch[p] <= acc_x[p] > PUNCH_DX_MIN && acc_y[p] < PUNCH_DY_MAX;
                        kick[p]  <= acc_y[p] > KICK_DY_MIN && acc_x[p] < KICK_DX_MAX;
                    end
                end
                {acc_x, acc_y, acc_s}             <= '0;
                {acc_x_neg, acc_y_neg, acc_s_neg} <= '0;
            end
        end
    end

    // index 0 is player 1
    assign p1_punch          = punch[0];
    assign p1_kick           = kick[0];
    assign p1_move_forwards  = fwd[0];
    assign p1_move_backwards = back[0];
    assign p2_punch          = punch[1];
    assign p2_kick           = kick[1];
    assign p2_move_forwards  = fwd[1];
    assign p2_move_backwards = back[1];

endmodule

/* frame_centroid_buffer.sv */
`timescale 1ns/1ps

module frame_centroid_buffer import gesture_pkg::*; (
    input  logic          clk_65mhz,
    input  logic          reset_8frame_delta_values,
    frame_stats_if.sink   stats,
    centroid_if.source    centroid
);

    logic [LAT_CNT_W-1:0]           busy_cnt;
    logic                           accept;
    logic                           done;
    logic                           update_q;
    pixel_count_t [NUM_PLAYERS-1:0] count_q;
    coord_sum_t   [NUM_PLAYERS-1:0] x_quo;
    coord_sum_t   [NUM_PLAYERS-1:0] y_quo;
    coord_x_t     [NUM_PLAYERS-1:0] x_q;
    coord_y_t     [NUM_PLAYERS-1:0] y_q;
    pixel_count_t [NUM_PLAYERS-1:0] size_q;

    // a frame closing mid-division is dropped
    assign accept = stats.frame_closed && busy_cnt == '0;
    assign done   = busy_cnt == LAT_CNT_W'(CENTROID_LATENCY - 1);

    for (genvar p = 0; p < NUM_PLAYERS; p++) begin : g_player
        serial_divider x_div_i (
            .clk_65mhz                 (clk_65mhz),
            .reset_8frame_delta_values (reset_8frame_delta_values),
            .start                     (accept),
            .dividend                  (stats.x_sum[p]),
            .divisor                   (stats.count[p]),
            .quotient                  (x_quo[p])
        );

        serial_divider y_div_i (
            .clk_65mhz                 (clk_65mhz),
            .reset_8frame_delta_values (reset_8frame_delta_values),
            .start                     (accept),
            .dividend                  (stats.y_sum[p]),
            .divisor                   (stats.count[p]),
            .quotient                  (y_quo[p])
        );
    end

    always_ff @(posedge clk_65mhz) begin
        if (reset_8frame_delta_values) begin
            busy_cnt <= '0;
            update_q <= 1'b0;
        end else begin
            update_q <= done;
            if (accept) begin
                busy_cnt <= LAT_CNT_W'(1);
            end else if (done) begin
                busy_cnt <= '0;
            end else if (busy_cnt != '0) begin
                busy_cnt <= busy_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_65mhz) begin
        if (accept) begin
            count_q <= stats.count;
        end
    end

    // empty frame keeps the old position
    always_ff @(posedge clk_65mhz) begin
        if (reset_8frame_delta_values) begin
            x_q    <= '0;
            y_q    <= '0;
            size_q <= '0;
        end else if (done) begin
            for (int p = 0; p < NUM_PLAYERS; p++) begin
                size_q[p] <= count_q[p];
                if (count_q[p] != '0) begin
                    x_q[p] <= coord_x_t'(x_quo[p]);
                    y_q[p] <= coord_y_t'(y_quo[p]);
                end
            end
        end
    end

    assign centroid.centroid_update = update_q;
    assign centroid.x               = x_q;
    assign centroid.y               = y_q;
    assign centroid.size            = size_q;

endmodule

/* serial_divider.sv */
`timescale 1ns/1ps

module serial_divider import gesture_pkg::*; (
    input  logic         clk_65mhz,
    input  logic         reset_8frame_delta_values,
    input  logic         start,
    input  coord_sum_t   dividend,
    input  pixel_count_t divisor,
    output coord_sum_t   quotient
);

    logic [DIV_CNT_W-1:0]          bits_left;
    pixel_count_t                  div_q;
    pixel_count_t                  div_src;
    pixel_count_t                  rem;
    pixel_count_t                  rem_src;
    pixel_count_t                  rem_next;
    coord_sum_t                    quo;
    coord_sum_t                    quo_src;
    logic [$bits(pixel_count_t):0] trial;
    logic                          fits;

    // one restoring step, the first one runs in the start cycle
    always_comb begin
        rem_src  = start ? '0 : rem;
        quo_src  = start ? dividend : quo;
        div_src  = start ? divisor : div_q;
        trial    = {rem_src, quo_src[DIV_BITS-1]};
        fits     = trial >= {1'b0, div_src};
        rem_next = fits ? pixel_count_t'(trial - {1'b0, div_src})
                        : trial[$bits(pixel_count_t)-1:0];
    end

    always_ff @(posedge clk_65mhz) begin
        if (reset_8frame_delta_values) begin
            bits_left <= '0;
        end else if (start) begin
            bits_left <= DIV_CNT_W'(DIV_BITS - 1);
        end else if (bits_left != '0) begin
            bits_left <= bits_left - 1'b1;
        end
    end

    // dividend bits shift out as quotient bits shift in
    always_ff @(posedge clk_65mhz) begin
        if (start) begin
            div_q <= divisor;
        end
        if (start || bits_left != '0) begin
            rem <= rem_next;
            quo <= {quo_src[DIV_BITS-2:0], fits};
        end
    end

    assign quotient = quo;

endmodule

/* led_pixel_accumulator.sv */
`timescale 1ns/1ps

module led_pixel_accumulator import gesture_pkg::*; (
    input  logic          clk_65mhz,
    input  logic          reset_8frame_delta_values,
    input  logic          pixel_valid,
    input  rgb444_t       pixel_rgb,
    input  coord_x_t      pixel_x,
    input  coord_y_t      pixel_y,
    input  logic          frame_done,
    frame_stats_if.source stats
);

    logic                           frame_done_q;
    logic                           frame_end;
    logic                           sample;
    logic [3:0]                     red;
    logic [3:0]                     green;
    logic [3:0]                     blue;
    logic                           is_p1;
    logic                           is_p2;
    logic [NUM_PLAYERS-1:0]         hit;
    pixel_count_t [NUM_PLAYERS-1:0] count;
    coord_sum_t   [NUM_PLAYERS-1:0] x_sum;
    coord_sum_t   [NUM_PLAYERS-1:0] y_sum;

    //////////////////////////////////////////////////////////////////////
    // pixel classification
    //////////////////////////////////////////////////////////////////////

    assign red   = pixel_rgb[11:8];
    assign green = pixel_rgb[7:4];
    assign blue  = pixel_rgb[3:0];

    // pixels only count between frames
    assign sample = pixel_valid && !frame_done;

    // bright red LED
    assign is_p1 = red > P1_RED_MIN && green < P1_OTHER_MAX && blue < P1_OTHER_MAX;
    // bright white LED, loses to red when both match
    assign is_p2 = !is_p1 && red > P2_ALL_MIN && green > P2_ALL_MIN && blue > P2_ALL_MIN;

    assign hit = {is_p2, is_p1} & {NUM_PLAYERS{sample}};

    //////////////////////////////////////////////////////////////////////
    // per-frame totals
    //////////////////////////////////////////////////////////////////////

    assign frame_end = frame_done_q && !frame_done;

    always_ff @(posedge clk_65mhz) begin
        if (reset_8frame_delta_values) begin
            frame_done_q <= 1'b0;
            count        <= '0;
            x_sum        <= '0;
            y_sum        <= '0;
        end else begin
            frame_done_q <= frame_done;
            for (int p = 0; p < NUM_PLAYERS; p++) begin
                if (frame_end) begin
                    // next frame starts with this cycle's pixel
                    count[p] <= hit[p] ? pixel_count_t'(1) : '0;
                    x_sum[p] <= hit[p] ? coord_sum_t'(pixel_x) : '0;
                    y_sum[p] <= hit[p] ? coord_sum_t'(pixel_y) : '0;
                end else if (hit[p]) begin
                    count[p] <= count[p] + 1'b1;
                    x_sum[p] <= x_sum[p] + coord_sum_t'(pixel_x);
                    y_sum[p] <= y_sum[p] + coord_sum_t'(pixel_y);
                end
            end
        end
    end

    assign stats.frame_closed = frame_end;
    assign stats.count        = count;
    assign stats.x_sum        = x_sum;
    assign stats.y_sum        = y_sum;

endmodule

/* centroid_if.sv */
`timescale 1ns/1ps

interface centroid_if import gesture_pkg::*; ();

    // held between strobes
    logic                           centroid_update;
    coord_x_t     [NUM_PLAYERS-1:0] x;
    coord_y_t     [NUM_PLAYERS-1:0] y;
    pixel_count_t [NUM_PLAYERS-1:0] size;

    modport source (
        output centroid_update,
        output x,
        output y,
        output size
    );

    modport sink (
        input centroid_update,
        input x,
        input y,
        input size
    );

endinterface

/* frame_stats_if.sv */
`timescale 1ns/1ps

interface frame_stats_if import gesture_pkg::*; ();

    // totals are only meaningful while frame_closed is high
    logic                           frame_closed;
    pixel_count_t [NUM_PLAYERS-1:0] count;
    coord_sum_t   [NUM_PLAYERS-1:0] x_sum;
    coord_sum_t   [NUM_PLAYERS-1:0] y_sum;

    modport source (
        output frame_closed,
        output count,
        output x_sum,
        output y_sum
    );

    modport sink (
        input frame_closed,
        input count,
        input x_sum,
        input y_sum
    );

endinterface

/* gesture_pkg.sv */
package gesture_pkg;

    localparam int NUM_PLAYERS = 2;

    // divider quotient width, also the width of a coordinate sum
    localparam int DIV_BITS = 24;
    // frame_closed to centroid_update
    localparam int CENTROID_LATENCY = 26;
    localparam int FRAMES_PER_MOTION = 8;

    localparam int DIV_CNT_W   = $clog2(DIV_BITS);
    localparam int LAT_CNT_W   = $clog2(CENTROID_LATENCY + 1);
    localparam int FRAME_CNT_W = $clog2(FRAMES_PER_MOTION);

    typedef logic [8:0]          coord_x_t;
    typedef logic [7:0]          coord_y_t;
    typedef logic [11:0]         rgb444_t;
    typedef logic [15:0]         pixel_count_t;
    typedef logic [DIV_BITS-1:0] coord_sum_t;
    typedef logic [8:0]          delta2_t;
    typedef logic [12:0]         delta8_t;

    // colour rules, per 4-bit channel
    localparam logic [3:0] P1_RED_MIN   = 4'd11;
    localparam logic [3:0] P1_OTHER_MAX = 4'd2;
    localparam logic [3:0] P2_ALL_MIN   = 4'd13;

    // 8-frame action thresholds
    localparam delta8_t MOVE_SIZE_MIN = 13'h30;
    localparam delta8_t PUNCH_DX_MIN  = 13'h40;
    localparam delta8_t PUNCH_DY_MAX  = 13'h30;
    localparam delta8_t KICK_DY_MIN   = 13'h40;
    localparam delta8_t KICK_DX_MAX   = 13'h30;

endpackage
